//--- build.f
verilog/usbEp0Pkg.sv
verilog/setupCapture.sv
verilog/deviceStateTracker.sv
verilog/replyBuilder.sv
verilog/replyStreamer.sv
verilog/usbEndpoint0.sv
verif/tbEndpoint0.sv

//--- runSim.sh
#!/bin/sh
# Builds the endpoint 0 testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tbEndpoint0 -o simEp0
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simEp0 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verif/ep0Cases.txt
# name rst nBytes b0 b1 b2 b3 b4 b5 b6 b7 ok creditMask outcome(0 drop,1 stall,2 reply) len exp0 exp1
# then state(0 not reset,1 default,2 addressed,3 configured) addr conf, all in hex
01 0 8 80 00 00 00 00 00 02 00 1 8000 1 0 00 00 0 00 00
02 0 8 00 05 05 00 00 00 00 00 1 8000 1 0 00 00 0 00 00
03 1 8 80 00 00 00 00 00 02 00 1 8000 1 0 00 00 1 00 00
04 0 8 00 05 05 00 00 00 00 00 1 8000 2 0 00 00 2 05 00
05 0 8 00 05 00 00 00 00 00 00 1 8000 2 0 00 00 1 00 00
06 0 8 00 05 12 00 00 00 00 00 1 8000 2 0 00 00 2 12 00
07 0 8 81 0a 00 00 00 00 01 00 1 8000 1 0 00 00 2 12 00
08 0 8 00 09 02 00 00 00 00 00 1 8000 1 0 00 00 2 12 00
09 0 8 00 09 01 00 00 00 00 00 1 8000 2 0 00 00 3 12 01
0a 0 8 80 08 00 00 00 00 01 00 1 0100 2 1 01 00 3 12 01
0b 0 8 80 00 00 00 00 00 02 00 1 1010 2 2 00 00 3 12 01
0c 0 8 80 00 00 00 00 00 01 00 1 0000 2 1 00 00 3 12 01
0d 0 8 81 0a 00 00 00 00 01 00 1 0000 2 1 00 00 3 12 01
0e 0 8 00 05 07 00 00 00 00 00 1 0000 1 0 00 00 3 12 01
0f 0 8 80 06 00 01 00 00 40 00 1 0000 1 0 00 00 3 12 01
10 0 8 c0 01 00 00 00 00 02 00 1 0000 1 0 00 00 3 12 01
11 0 8 00 09 00 00 00 00 00 00 0 0000 0 0 00 00 3 12 01
12 0 6 80 00 00 00 00 00 02 00 1 0000 0 0 00 00 3 12 01
13 0 8 80 08 00 00 00 00 40 00 1 ffff 2 1 01 00 3 12 01
14 0 8 81 00 00 00 00 00 02 00 1 0000 1 0 00 00 3 12 01
15 1 8 80 08 00 00 00 00 01 00 1 0000 1 0 00 00 1 00 00
16 0 9 00 05 03 00 00 00 00 00 1 0000 2 0 00 00 2 03 00

//--- verif/tbEndpoint0.sv
`timescale 1ns/10ps

module tbEndpoint0
    import usbEp0Pkg::*;
();

    localparam logic [31:0] LFSR_SEED = 32'h75a1_5f94;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int RESULT_TIMEOUT = 64;
    localparam int DROP_WINDOW = 16;
    localparam int OUT_DROP = 0;
    localparam int OUT_STALL = 1;
    localparam int OUT_REPLY = 2;
    localparam int NUM_FIELDS = 20;

    logic clk48;
    logic rstN;
    logic usbReset;
    logic setupValid;
    logic [7:0] setupByte;
    logic setupDone;
    logic setupOk;
    logic inCredit;
    logic inValid;
    logic [7:0] inByte;
    logic stall;
    logic replyDone;
    DeviceState deviceState;
    logic [ADDR_WID-1:0] deviceAddr;
    logic [CONF_WID-1:0] deviceConf;

    // One case line, see the header of the case file for the columns
    logic [31:0] fld [NUM_FIELDS];
    logic [15:0] caseName;
    logic [31:0] lfsrState;

    // Reference credit count and what the endpoint sent
    int creditModel;
    int stallCount;
    int doneCount;
    logic [7:0] rxBytes [$];

    usbEndpoint0 usbEndpoint0_inst (
        .clk48_i       (clk48),
        .rstN_i        (rstN),
        .usbReset_i    (usbReset),
        .setupValid_i  (setupValid),
        .setupByte_i   (setupByte),
        .setupDone_i   (setupDone),
        .setupOk_i     (setupOk),
        .inCredit_i    (inCredit),
        .inValid_o     (inValid),
        .inByte_o      (inByte),
        .stall_o       (stall),
        .replyDone_o   (replyDone),
        .deviceState_o (deviceState),
        .deviceAddr_o  (deviceAddr),
        .deviceConf_o  (deviceConf)
    );

    initial begin
        clk48 = 1'b0;
        forever #4 clk48 = ~clk48;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkByte(input string what, input logic [7:0] expVal,
                             input logic [7:0] actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("Fail %h %s: expected %h, actual %h",
                               caseName, what, expVal, actVal));
        end
    endtask

    task automatic checkState(input string what, input DeviceState expVal,
                              input DeviceState actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("Fail %h %s: expected %s, actual %s",
                               caseName, what, expVal.name(), actVal.name()));
        end
    endtask

    task automatic checkAddr(input string what, input logic [ADDR_WID-1:0] expVal,
                             input logic [ADDR_WID-1:0] actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("Fail %h %s: expected %h, actual %h",
                               caseName, what, expVal, actVal));
        end
    endtask

    task automatic checkConf(input string what, input logic [CONF_WID-1:0] expVal,
                             input logic [CONF_WID-1:0] actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("Fail %h %s: expected %h, actual %h",
                               caseName, what, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string what, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("Fail %h %s: expected %b, actual %b",
                               caseName, what, expVal, actVal));
        end
    endtask

    // Galois form, shifting right
    function automatic logic [31:0] stepLfsr(input logic [31:0] cur);
        logic [31:0] nxt;
        nxt = cur >> 1;
        if (cur[0]) begin
            nxt = nxt ^ LFSR_TAPS;
        end
        return nxt;
    endfunction

    // Outputs are sampled half a cycle after the edge
    always @(negedge clk48) begin
        int nextCredit;
        if (!rstN) begin
            creditModel = 0;
        end else begin
            if (inValid && creditModel == 0) begin
                abortRun("A reply byte left the endpoint without a credit");
            end
            if (inValid) begin
                rxBytes.push_back(inByte);
            end
            if (stall) begin
                stallCount++;
            end
            if (replyDone) begin
                doneCount++;
            end
            nextCredit = creditModel + int'(inCredit) - int'(inValid);
            creditModel = (nextCredit > CREDIT_MAX) ? CREDIT_MAX : nextCredit;
        end
    end

    task automatic pulseBusReset();
        @(posedge clk48);
        usbReset <= 1'b1;
        @(posedge clk48);
        usbReset <= 1'b0;
    endtask

    // Bytes past the eighth carry ff
    task automatic sendSetup();
        int i;
        for (i = 0; i < int'(fld[2]); i++) begin
            @(posedge clk48);
            setupValid <= 1'b1;
            setupByte <= (i < SETUP_BYTES) ? fld[3+i][7:0] : 8'hff;
        end
        @(posedge clk48);
        setupValid <= 1'b0;
        setupDone <= 1'b1;
        setupOk <= fld[11][0];
        @(posedge clk48);
        setupDone <= 1'b0;
        setupOk <= 1'b0;
    endtask

    // Mask bit for this cycle, or a fresh random bit when the mask is zero
    task automatic driveCredit(input int idx);
        logic creditBit;
        @(posedge clk48);
        if (fld[12][15:0] != 16'h0000) begin
            creditBit = fld[12][idx % 16];
        end else begin
            lfsrState = stepLfsr(lfsrState);
            creditBit = lfsrState[0];
        end
        inCredit <= creditBit;
    endtask

    task automatic runCase();
        int idx;
        int outcome;
        int i;
        caseName = fld[0][15:0];
        outcome = int'(fld[13]);
        if (fld[1][0]) begin
            pulseBusReset();
        end
        stallCount = 0;
        doneCount = 0;
        rxBytes.delete();
        sendSetup();
        idx = 0;
        if (outcome == OUT_DROP) begin
            while (idx < DROP_WINDOW) begin
                driveCredit(idx);
                @(negedge clk48);
                idx++;
            end
        end else begin
            while (!stall && !replyDone) begin
                if (idx >= RESULT_TIMEOUT) begin
                    abortRun($sformatf("Case %h got neither a stall nor a reply done",
                                       caseName));
                end
                driveCredit(idx);
                @(negedge clk48);
                idx++;
            end
        end
        @(posedge clk48);
        inCredit <= 1'b0;
        checkFlag("stall", outcome == OUT_STALL, stallCount != 0);
        checkFlag("reply done", outcome == OUT_REPLY, doneCount != 0);
        checkByte("reply length", fld[14][7:0], 8'(rxBytes.size()));
        for (i = 0; i < rxBytes.size(); i++) begin
            checkByte($sformatf("reply byte %0d", i), fld[15+i][7:0], rxBytes[i]);
        end
        checkState("device state", DeviceState'(fld[17][1:0]), deviceState);
        checkAddr("device address", fld[18][ADDR_WID-1:0], deviceAddr);
        checkConf("configuration", fld[19][CONF_WID-1:0], deviceConf);
    endtask

    initial begin
        int fd;
        int fieldCnt;
        int casesRun;
        string line;
        rstN <= 1'b0;
        usbReset <= 1'b0;
        setupValid <= 1'b0;
        setupByte <= 8'h00;
        setupDone <= 1'b0;
        setupOk <= 1'b0;
        inCredit <= 1'b0;
        lfsrState = LFSR_SEED;
        stallCount = 0;
        doneCount = 0;
        casesRun = 0;
        repeat (16) @(posedge clk48);
        rstN <= 1'b1;
        @(posedge clk48);
        fd = $fopen("verif/ep0Cases.txt", "r");
        if (fd == 0) begin
            abortRun("Cannot open the case file verif/ep0Cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fieldCnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                               fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                               fld[14], fld[15], fld[16], fld[17], fld[18], fld[19]);
            if (fieldCnt != NUM_FIELDS) begin
                abortRun($sformatf("Malformed case line: %s", line));
            end
            runCase();
            casesRun++;
        end
        $fclose(fd);
        if (casesRun == 0) begin
            abortRun("The case file holds no cases");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- verilog/deviceStateTracker.sv
`timescale 1ns/10ps

module deviceStateTracker
    import usbEp0Pkg::*;
(
    input  logic                clk48_i,
    input  logic                rstN_i,
    input  logic                usbReset_i,
    input  logic                reqValid_i,
    input  ReqOpcode            reqOpcode_i,
    input  logic                reqDirIn_i,
    input  logic [1:0]          reqType_i,
    input  logic [4:0]          reqRecipient_i,
    input  logic [15:0]         reqValue_i,
    input  logic [15:0]         reqIndex_i,
    input  logic [15:0]         reqLength_i,
    output logic                verdictValid_o,
    output logic                reqAccept_o,
    output DeviceState          deviceState_o,
    output logic [ADDR_WID-1:0] deviceAddr_o,
    output logic [CONF_WID-1:0] deviceConf_o
);

    DeviceState nextState;
    logic [ADDR_WID-1:0] nextAddr;
    logic [CONF_WID-1:0] nextConf;
    logic accept;
    logic isStandard;
    logic addrOrConf;
    logic toDevice;

    // Nothing but a bus reset is honoured before the first reset
    assign isStandard = (reqType_i == REQ_TYPE_STANDARD) && (deviceState_o != DEV_NOT_RESET);
    assign addrOrConf = (deviceState_o == DEV_ADDRESSED) || (deviceState_o == DEV_CONFIGURED);
    assign toDevice = reqRecipient_i == REQ_RCPT_DEVICE;

    always_comb begin
        accept = 1'b0;
        nextState = deviceState_o;
        nextAddr = deviceAddr_o;
        nextConf = deviceConf_o;
        if (usbReset_i) begin
            nextState = DEV_DEFAULT;
            nextAddr = '0;
            nextConf = '0;
        end else if (reqValid_i && isStandard) begin
            case (reqOpcode_i)
                SET_ADDRESS: begin
                    accept = !reqDirIn_i && toDevice && (reqIndex_i == '0)
                             && (reqLength_i == '0) && (reqValue_i[15:ADDR_WID] == '0)
                             && (deviceState_o != DEV_CONFIGURED);
                    if (accept) begin
                        nextAddr = reqValue_i[ADDR_WID-1:0];
                        nextState = (nextAddr == '0) ? DEV_DEFAULT : DEV_ADDRESSED;
                    end
                end
                SET_CONFIGURATION: begin
                    accept = addrOrConf && (reqValue_i <= 16'(NUM_CONFIGS))
                             && (reqLength_i == '0);
                    if (accept) begin
                        nextConf = reqValue_i[CONF_WID-1:0];
                        nextState = (nextConf == '0) ? DEV_ADDRESSED : DEV_CONFIGURED;
                    end
                end
                GET_STATUS:
                    accept = reqDirIn_i && toDevice && (reqLength_i != '0) && addrOrConf;
                GET_CONFIGURATION:
                    accept = reqDirIn_i && (reqLength_i != '0) && addrOrConf;
                GET_INTERFACE:
                    accept = reqDirIn_i && (reqLength_i != '0)
                             && (deviceState_o == DEV_CONFIGURED);
                default:
                    accept = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            deviceState_o <= DEV_NOT_RESET;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
            verdictValid_o <= 1'b0;
            reqAccept_o <= 1'b0;
        end else begin
            deviceState_o <= nextState;
            deviceAddr_o <= nextAddr;
            deviceConf_o <= nextConf;
            verdictValid_o <= reqValid_i;
            reqAccept_o <= accept;
        end
    end

endmodule

//--- verilog/replyBuilder.sv
`timescale 1ns/10ps

module replyBuilder
    import usbEp0Pkg::*;
(
    input  logic                     clk48_i,
    input  logic                     rstN_i,
    input  logic                     reqValid_i,
    input  ReqOpcode                 reqOpcode_i,
    input  logic [15:0]              reqLength_i,
    input  logic [CONF_WID-1:0]      deviceConf_i,
    output logic                     replyValid_o,
    output logic [REPLY_LEN_WID-1:0] replyLen_o,
    output logic [7:0]               replyByte0_o,
    output logic [7:0]               replyByte1_o
);

    logic [REPLY_LEN_WID-1:0] natLen;
    logic [REPLY_LEN_WID-1:0] cutLen;
    logic [7:0] natByte0;

    always_comb begin
        natLen = '0;
        natByte0 = 8'h00;
        case (reqOpcode_i)
            // Bus powered, remote wakeup off
            GET_STATUS:
                natLen = LEN_GET_STATUS;
            GET_CONFIGURATION: begin
                natLen = LEN_GET_CONFIGURATION;
                natByte0 = deviceConf_i;
            end
            // Only alternate setting zero exists
            GET_INTERFACE:
                natLen = LEN_GET_INTERFACE;
            default:
                natLen = '0;
        endcase
    end

    // Host may ask for less than the natural reply
    assign cutLen = (reqLength_i < 16'(natLen)) ? reqLength_i[REPLY_LEN_WID-1:0] : natLen;

    // High byte of the status word is always zero
    assign replyByte1_o = 8'h00;

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            replyValid_o <= 1'b0;
        end else begin
            replyValid_o <= reqValid_i;
        end
    end

    always_ff @(posedge clk48_i) begin
        if (reqValid_i) begin
            replyLen_o <= cutLen;
            replyByte0_o <= natByte0;
        end
    end

endmodule

//--- verilog/replyStreamer.sv
`timescale 1ns/10ps

module replyStreamer
    import usbEp0Pkg::*;
(
    input  logic                     clk48_i,
    input  logic                     rstN_i,
    input  logic                     verdictValid_i,
    input  logic                     reqAccept_i,
    input  logic                     replyValid_i,
    input  logic [REPLY_LEN_WID-1:0] replyLen_i,
    input  logic [7:0]               replyByte0_i,
    input  logic [7:0]               replyByte1_i,
    input  logic                     inCredit_i,
    output logic                     inValid_o,
    output logic [7:0]               inByte_o,
    output logic                     stall_o,
    output logic                     replyDone_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_DONE
    } StreamState;

    StreamState state;
    logic [CREDIT_WID-1:0] creditCnt;
    logic [REPLY_LEN_WID-1:0] lenReg;
    logic [7:0] byte0Reg;
    logic [7:0] byte1Reg;
    logic sendIdx;
    logic resultValid;
    logic lastByte;

    assign resultValid = verdictValid_i && replyValid_i;
    // A fresh result cuts off whatever is still being sent
    assign inValid_o = (state == ST_SEND) && (creditCnt != '0) && !resultValid;
    assign inByte_o = sendIdx ? byte1Reg : byte0Reg;
    assign lastByte = (REPLY_LEN_WID'(sendIdx) + 1'b1) == lenReg;
    assign replyDone_o = state == ST_DONE;

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= ST_IDLE;
            creditCnt <= '0;
            sendIdx <= 1'b0;
            stall_o <= 1'b0;
        end else begin
            // Credit in minus byte out, saturating at the top
            if (inCredit_i && !inValid_o && creditCnt != CREDIT_WID'(CREDIT_MAX)) begin
                creditCnt <= creditCnt + 1'b1;
            end else if (!inCredit_i && inValid_o) begin
                creditCnt <= creditCnt - 1'b1;
            end
            stall_o <= resultValid && !reqAccept_i;
            if (resultValid) begin
                sendIdx <= 1'b0;
                if (!reqAccept_i) begin
                    state <= ST_IDLE;
                end else if (replyLen_i == '0) begin
                    state <= ST_DONE;
                end else begin
                    state <= ST_SEND;
                end
            end else if (state == ST_SEND && inValid_o) begin
                sendIdx <= 1'b1;
                if (lastByte) begin
                    state <= ST_DONE;
                end
            end else if (state == ST_DONE) begin
                state <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (resultValid) begin
            lenReg <= replyLen_i;
            byte0Reg <= replyByte0_i;
            byte1Reg <= replyByte1_i;
        end
    end

endmodule

//--- verilog/setupCapture.sv
`timescale 1ns/10ps

module setupCapture
    import usbEp0Pkg::*;
(
    input  logic        clk48_i,
    input  logic        rstN_i,
    input  logic        usbReset_i,
    input  logic        setupValid_i,
    input  logic [7:0]  setupByte_i,
    input  logic        setupDone_i,
    input  logic        setupOk_i,
    output logic        reqValid_o,
    output ReqOpcode    reqOpcode_o,
    output logic        reqDirIn_o,
    output logic [1:0]  reqType_o,
    output logic [4:0]  reqRecipient_o,
    output logic [15:0] reqValue_o,
    output logic [15:0] reqIndex_o,
    output logic [15:0] reqLength_o
);

    logic [7:0] setupBuf [SETUP_BYTES];
    logic [SETUP_CNT_WID-1:0] byteCnt;
    logic byteAccept;
    logic packetGood;

    // Only the standard codes get their own opcode
    function automatic ReqOpcode decodeRequest(input logic [7:0] bRequest);
        ReqOpcode op;
        case (bRequest)
            8'd0:    op = GET_STATUS;
            8'd1:    op = CLEAR_FEATURE;
            8'd3:    op = SET_FEATURE;
            8'd5:    op = SET_ADDRESS;
            8'd6:    op = GET_DESCRIPTOR;
            8'd7:    op = SET_DESCRIPTOR;
            8'd8:    op = GET_CONFIGURATION;
            8'd9:    op = SET_CONFIGURATION;
            8'd10:   op = GET_INTERFACE;
            8'd11:   op = SET_INTERFACE;
            8'd12:   op = SYNCH_FRAME;
            default: op = REQ_UNSUPPORTED;
        endcase
        return op;
    endfunction

    // Bytes past the eighth are dropped
    assign byteAccept = setupValid_i && (byteCnt < SETUP_CNT_WID'(SETUP_BYTES));
    assign packetGood = setupDone_i && setupOk_i && !usbReset_i
                        && (byteCnt == SETUP_CNT_WID'(SETUP_BYTES));

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            byteCnt <= '0;
            reqValid_o <= 1'b0;
        end else begin
            reqValid_o <= packetGood;
            if (setupDone_i || usbReset_i) begin
                byteCnt <= '0;
            end else if (byteAccept) begin
                byteCnt <= byteCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (byteAccept) begin
            setupBuf[byteCnt[SETUP_IDX_WID-1:0]] <= setupByte_i;
        end
    end

    // Little-endian word fields
    always_ff @(posedge clk48_i) begin
        if (packetGood) begin
            reqDirIn_o <= setupBuf[0][7];
            reqType_o <= setupBuf[0][6:5];
            reqRecipient_o <= setupBuf[0][4:0];
            reqOpcode_o <= decodeRequest(setupBuf[1]);
            reqValue_o <= {setupBuf[3], setupBuf[2]};
            reqIndex_o <= {setupBuf[5], setupBuf[4]};
            reqLength_o <= {setupBuf[7], setupBuf[6]};
        end
    end

endmodule

//--- verilog/usbEndpoint0.sv
`timescale 1ns/10ps

module usbEndpoint0
    import usbEp0Pkg::*;
(
    input  logic                clk48_i,
    input  logic                rstN_i,
    input  logic                usbReset_i,
    input  logic                setupValid_i,
    input  logic [7:0]          setupByte_i,
    input  logic                setupDone_i,
    input  logic                setupOk_i,
    input  logic                inCredit_i,
    output logic                inValid_o,
    output logic [7:0]          inByte_o,
    output logic                stall_o,
    output logic                replyDone_o,
    output DeviceState          deviceState_o,
    output logic [ADDR_WID-1:0] deviceAddr_o,
    output logic [CONF_WID-1:0] deviceConf_o
);

    // Decoded request
    logic reqValid;
    ReqOpcode reqOpcode;
    logic reqDirIn;
    logic [1:0] reqType;
    logic [4:0] reqRecipient;
    logic [15:0] reqValue;
    logic [15:0] reqIndex;
    logic [15:0] reqLength;

    // Verdict and reply
    logic verdictValid;
    logic reqAccept;
    logic replyValid;
    logic [REPLY_LEN_WID-1:0] replyLen;
    logic [7:0] replyByte0;
    logic [7:0] replyByte1;

    setupCapture setupCapture_inst (
        .clk48_i        (clk48_i),
        .rstN_i         (rstN_i),
        .usbReset_i     (usbReset_i),
        .setupValid_i   (setupValid_i),
        .setupByte_i    (setupByte_i),
        .setupDone_i    (setupDone_i),
        .setupOk_i      (setupOk_i),
        .reqValid_o     (reqValid),
        .reqOpcode_o    (reqOpcode),
        .reqDirIn_o     (reqDirIn),
        .reqType_o      (reqType),
        .reqRecipient_o (reqRecipient),
        .reqValue_o     (reqValue),
        .reqIndex_o     (reqIndex),
        .reqLength_o    (reqLength)
    );

    deviceStateTracker deviceStateTracker_inst (
        .clk48_i        (clk48_i),
        .rstN_i         (rstN_i),
        .usbReset_i     (usbReset_i),
        .reqValid_i     (reqValid),
        .reqOpcode_i    (reqOpcode),
        .reqDirIn_i     (reqDirIn),
        .reqType_i      (reqType),
        .reqRecipient_i (reqRecipient),
        .reqValue_i     (reqValue),
        .reqIndex_i     (reqIndex),
        .reqLength_i    (reqLength),
        .verdictValid_o (verdictValid),
        .reqAccept_o    (reqAccept),
        .deviceState_o  (deviceState_o),
        .deviceAddr_o   (deviceAddr_o),
        .deviceConf_o   (deviceConf_o)
    );

    // Sees the configuration from before this request's update
    replyBuilder replyBuilder_inst (
        .clk48_i      (clk48_i),
        .rstN_i       (rstN_i),
        .reqValid_i   (reqValid),
        .reqOpcode_i  (reqOpcode),
        .reqLength_i  (reqLength),
        .deviceConf_i (deviceConf_o),
        .replyValid_o (replyValid),
        .replyLen_o   (replyLen),
        .replyByte0_o (replyByte0),
        .replyByte1_o (replyByte1)
    );

    replyStreamer replyStreamer_inst (
        .clk48_i        (clk48_i),
        .rstN_i         (rstN_i),
        .verdictValid_i (verdictValid),
        .reqAccept_i    (reqAccept),
        .replyValid_i   (replyValid),
        .replyLen_i     (replyLen),
        .replyByte0_i   (replyByte0),
        .replyByte1_i   (replyByte1),
        .inCredit_i     (inCredit_i),
        .inValid_o      (inValid_o),
        .inByte_o       (inByte_o),
        .stall_o        (stall_o),
        .replyDone_o    (replyDone_o)
    );

endmodule

//--- verilog/usbEp0Pkg.sv
package usbEp0Pkg;

    // Setup stage layout
    localparam int SETUP_BYTES = 8;
    localparam int SETUP_IDX_WID = $clog2(SETUP_BYTES);
    localparam int SETUP_CNT_WID = SETUP_IDX_WID + 1;

    // Device identity widths
    localparam int ADDR_WID = 7;
    localparam int CONF_WID = 8;
    localparam int NUM_CONFIGS = 1;

    // Reply stream sizing
    localparam int CREDIT_MAX = 8;
    localparam int CREDIT_WID = $clog2(CREDIT_MAX + 1);
    localparam int REPLY_MAX = 2;
    localparam int REPLY_LEN_WID = $clog2(REPLY_MAX + 1);

    // Natural reply lengths of the GET requests
    localparam logic [REPLY_LEN_WID-1:0] LEN_GET_STATUS = REPLY_LEN_WID'(2);
    localparam logic [REPLY_LEN_WID-1:0] LEN_GET_CONFIGURATION = REPLY_LEN_WID'(1);
    localparam logic [REPLY_LEN_WID-1:0] LEN_GET_INTERFACE = REPLY_LEN_WID'(1);

    // bmRequestType field codes
    localparam logic [1:0] REQ_TYPE_STANDARD = 2'b00;
    localparam logic [4:0] REQ_RCPT_DEVICE = 5'd0;

    // Standard request codes, values as in bRequest
    typedef enum logic [3:0] {
        GET_STATUS        = 4'd0,
        CLEAR_FEATURE     = 4'd1,
        SET_FEATURE       = 4'd3,
        SET_ADDRESS       = 4'd5,
        GET_DESCRIPTOR    = 4'd6,
        SET_DESCRIPTOR    = 4'd7,
        GET_CONFIGURATION = 4'd8,
        SET_CONFIGURATION = 4'd9,
        GET_INTERFACE     = 4'd10,
        SET_INTERFACE     = 4'd11,
        SYNCH_FRAME       = 4'd12,
        REQ_UNSUPPORTED   = 4'd15
    } ReqOpcode;

    // USB device states, suspend not modelled
    typedef enum logic [1:0] {
        DEV_NOT_RESET,
        DEV_DEFAULT,
        DEV_ADDRESSED,
        DEV_CONFIGURED
    } DeviceState;

endpackage
